/* verilog/f8_pkg.sv */
/*
  Shared widths, opcodes and bus structs for the reduced f8 core.
  Opcode values are local to this core and not binary compatible with f8.
  Opcodes not listed here decode as one-byte nops.
  Byte enables are ordered low lane first, bit 0 is the byte at the address.
*/
package f8_pkg;

	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;
	localparam int BANK_ADDR_W = 15;
	localparam logic [ADDR_W-1:0] RESET_PC = 16'h4000;

	typedef enum logic [7:0]
	{
		OP_NOP         = 8'h00,
		OP_TRAP        = 8'h01,
		OP_LD_XL_IMMD  = 8'h10,
		OP_LD_XL_DIR   = 8'h11,
		OP_LD_XL_IY    = 8'h12,
		OP_LD_DIR_XL   = 8'h13,
		OP_LDW_Y_IMMD  = 8'h14,
		OP_ADD_XL_IMMD = 8'h20,
		OP_SUB_XL_IMMD = 8'h21,
		OP_AND_XL_IMMD = 8'h22,
		OP_OR_XL_IMMD  = 8'h23,
		OP_XOR_XL_IMMD = 8'h24,
		OP_ADD_XL_DIR  = 8'h25,
		OP_JR_D        = 8'h30,
		OP_JRZ_D       = 8'h31,
		OP_JRNZ_D      = 8'h32,
		OP_JRC_D       = 8'h33,
		OP_JP_IMMD     = 8'h34
	} opcode_t;

	typedef enum logic [1:0]
	{
		PHASE_EXEC    = 2'd0,
		PHASE_UPPER   = 2'd1,
		PHASE_OPERAND = 2'd2
	} fetch_phase_t;

	typedef struct packed
	{
		logic z;
		logic n;
		logic c;
	} flags_t;

	typedef struct packed
	{
		logic target_y;
		logic [1:0] be;
		logic [2*DATA_W-1:0] data;
	} reg_write_t;

	typedef struct packed
	{
		logic [ADDR_W-1:0] addr;
		logic [2*DATA_W-1:0] data;
		logic [1:0] be;
	} mem_write_t;

	typedef struct packed
	{
		logic [BANK_ADDR_W-1:0] read_addr;
		logic [BANK_ADDR_W-1:0] write_addr;
		logic [DATA_W-1:0] write_data;
		logic write_en;
	} bank_port_t;

	function automatic logic [1:0] instsize(opcode_t opcode);
		case (opcode)
			OP_LD_XL_DIR, OP_LD_DIR_XL, OP_LDW_Y_IMMD, OP_ADD_XL_DIR, OP_JP_IMMD:
				return 2'd3;
			OP_LD_XL_IMMD, OP_ADD_XL_IMMD, OP_SUB_XL_IMMD, OP_AND_XL_IMMD,
			OP_OR_XL_IMMD, OP_XOR_XL_IMMD, OP_JR_D, OP_JRZ_D, OP_JRNZ_D, OP_JRC_D:
				return 2'd2;
			default:
				return 2'd1;
		endcase
	endfunction

endpackage

/* verilog/f8_regfile.sv */
/*
  Architectural state of the core: x, y, flags and pc.
  x and y have no reset and hold X until first written.
*/
`timescale 1ns/1ps

module f8_regfile import f8_pkg::*;
(
	input logic clk,
	input logic reset,
	input reg_write_t reg_write,
	input flags_t next_flags,
	input logic [ADDR_W-1:0] next_pc,
	output logic [ADDR_W-1:0] x,
	output logic [ADDR_W-1:0] y,
	output logic [ADDR_W-1:0] pc,
	output flags_t flags
);

	always_ff @(posedge clk)
	begin
		if (reg_write.be[0])
		begin
			if (reg_write.target_y)
				y[7:0] <= reg_write.data[7:0];
			else
				x[7:0] <= reg_write.data[7:0];
		end
		if (reg_write.be[1])
		begin
			if (reg_write.target_y)
				y[15:8] <= reg_write.data[15:8];
			else
				x[15:8] <= reg_write.data[15:8];
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			flags <= '0;
			pc <= RESET_PC;
		end
		else
		begin
			flags <= next_flags;
			pc <= next_pc;
		end
	end

endmodule

/* verilog/f8_mem_arbiter.sv */
/*
  Maps 16-bit byte accesses onto the even and odd memory banks.
  Banks must have a one-cycle synchronous read and be always ready.
  An odd address reads the even bank one bank word higher, so any
  two consecutive bytes come back in one cycle.
*/
`timescale 1ns/1ps

module f8_mem_arbiter import f8_pkg::*;
(
	input logic clk,
	input logic reset,
	input fetch_phase_t phase,
	input logic [ADDR_W-1:0] fetch_addr,
	input logic [ADDR_W-1:0] operand_addr,
	input mem_write_t mem_write,
	input logic [DATA_W-1:0] read_data_even,
	input logic [DATA_W-1:0] read_data_odd,
	output bank_port_t bank_even,
	output bank_port_t bank_odd,
	output logic [ADDR_W-1:0] read_word
);

	logic [ADDR_W-1:0] read_addr;
	logic [BANK_ADDR_W-1:0] read_carry;
	logic [BANK_ADDR_W-1:0] write_carry;
	logic read_odd_q;
	logic write_odd;

	always_comb
	begin
		case (phase)
			PHASE_OPERAND: read_addr = operand_addr;
			default: read_addr = fetch_addr;
		endcase
	end

	assign read_carry = {{(BANK_ADDR_W-1){1'b0}}, read_addr[0]};
	assign write_odd = mem_write.addr[0];
	assign write_carry = {{(BANK_ADDR_W-1){1'b0}}, write_odd};

	assign bank_odd.read_addr = read_addr[ADDR_W-1:1];
	assign bank_even.read_addr = read_addr[ADDR_W-1:1] + read_carry;

	// alignment of the word arriving next cycle
	always_ff @(posedge clk)
	begin
		if (reset)
			read_odd_q <= 1'b0;
		else
			read_odd_q <= read_addr[0];
	end

	assign read_word = read_odd_q ? {read_data_even, read_data_odd} :
		{read_data_odd, read_data_even};

	// odd start address puts the low byte on the odd bank
	assign bank_odd.write_addr = mem_write.addr[ADDR_W-1:1];
	assign bank_even.write_addr = mem_write.addr[ADDR_W-1:1] + write_carry;
	assign bank_even.write_data = write_odd ? mem_write.data[15:8] : mem_write.data[7:0];
	assign bank_odd.write_data = write_odd ? mem_write.data[7:0] : mem_write.data[15:8];
	assign bank_even.write_en = write_odd ? mem_write.be[1] : mem_write.be[0];
	assign bank_odd.write_en = write_odd ? mem_write.be[0] : mem_write.be[1];

endmodule

/* verilog/f8_fetch.sv */
/*
  Fetch sequencer. Two instruction bytes arrive per cycle; a third
  byte costs one PHASE_UPPER cycle and a memory operand one
  PHASE_OPERAND cycle. execute is high once per instruction.
  While reset is high the instruction is forced to nop and pc holds.
*/
`timescale 1ns/1ps

module f8_fetch import f8_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic [ADDR_W-1:0] read_word,
	input logic [ADDR_W-1:0] pc,
	input logic branch_taken,
	input logic [ADDR_W-1:0] branch_target,
	input logic trap,
	output logic [23:0] inst,
	output logic execute,
	output fetch_phase_t phase,
	output logic [ADDR_W-1:0] fetch_addr,
	output logic [ADDR_W-1:0] next_pc
);

	opcode_t opcode;
	logic [23:0] held_inst;
	logic upper_valid;
	logic operand_valid;
	logic loads_operand;
	logic need_upper;
	logic need_operand;

	always_comb
	begin
		if (reset)
			inst = {16'h0000, OP_NOP};
		else if (upper_valid)
			// word was read at pc+1, so its high byte is the third byte
			inst = {read_word[15:8], held_inst[15:0]};
		else if (operand_valid)
			inst = held_inst;
		else
			inst = {8'h00, read_word};
	end

	assign opcode = opcode_t'(inst[7:0]);
	assign loads_operand = (opcode == OP_LD_XL_DIR) || (opcode == OP_LD_XL_IY) ||
		(opcode == OP_ADD_XL_DIR);

	assign need_upper = (instsize(opcode) == 2'd3) && !upper_valid && !operand_valid;
	assign need_operand = loads_operand && !operand_valid && !need_upper;
	assign execute = !reset && !need_upper && !need_operand;

	always_comb
	begin
		if (need_upper)
			phase = PHASE_UPPER;
		else if (need_operand)
			phase = PHASE_OPERAND;
		else
			phase = PHASE_EXEC;
	end

	always_comb
	begin
		if (!execute || trap)
			next_pc = pc;
		else if (branch_taken)
			next_pc = branch_target;
		else
			next_pc = pc + {{(ADDR_W-2){1'b0}}, instsize(opcode)};
	end

	assign fetch_addr = (phase == PHASE_UPPER) ? pc + 16'd1 : next_pc;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			held_inst <= {16'h0000, OP_NOP};
			upper_valid <= 1'b0;
			operand_valid <= 1'b0;
		end
		else
		begin
			held_inst <= inst;
			upper_valid <= (phase == PHASE_UPPER);
			operand_valid <= (phase == PHASE_OPERAND);
		end
	end

endmodule

/* verilog/f8_execute.sv */
/*
  Decode and execute for the reduced instruction set, purely combinational.
  Relative branch targets are pc of the branch plus the signed displacement.
  Loads from memory set Z and N; ld xl with an immediate leaves flags alone.
  All write strobes are low unless execute is high.
*/
`timescale 1ns/1ps

module f8_execute import f8_pkg::*;
(
	input logic [23:0] inst,
	input logic execute,
	input logic [ADDR_W-1:0] read_word,
	input logic [ADDR_W-1:0] x,
	input logic [ADDR_W-1:0] y,
	input logic [ADDR_W-1:0] pc,
	input flags_t flags,
	output logic [ADDR_W-1:0] operand_addr,
	output reg_write_t reg_write,
	output flags_t next_flags,
	output mem_write_t mem_write,
	output logic branch_taken,
	output logic [ADDR_W-1:0] branch_target,
	output logic trap
);

	opcode_t opcode;
	logic [DATA_W-1:0] imm8;
	logic [DATA_W-1:0] mem8;
	logic [DATA_W-1:0] op8;
	logic [DATA_W-1:0] alu_res;
	logic [DATA_W:0] sum9;
	logic [ADDR_W-1:0] rel_target;

	assign opcode = opcode_t'(inst[7:0]);
	assign imm8 = inst[15:8];
	assign mem8 = read_word[7:0];
	assign op8 = (opcode == OP_ADD_XL_DIR) ? mem8 : imm8;
	assign operand_addr = (opcode == OP_LD_XL_IY) ? y : inst[23:8];
	assign rel_target = pc + {{8{imm8[7]}}, imm8};
	assign trap = (opcode == OP_TRAP);

	// sub is x + ~op + 1, carry set means no borrow
	always_comb
	begin
		if (opcode == OP_SUB_XL_IMMD)
			sum9 = {1'b0, x[7:0]} + {1'b0, ~op8} + 9'd1;
		else
			sum9 = {1'b0, x[7:0]} + {1'b0, op8};
		case (opcode)
			OP_AND_XL_IMMD: alu_res = x[7:0] & op8;
			OP_OR_XL_IMMD: alu_res = x[7:0] | op8;
			OP_XOR_XL_IMMD: alu_res = x[7:0] ^ op8;
			default: alu_res = sum9[7:0];
		endcase
	end

	always_comb
	begin
		reg_write = '{target_y: 1'b0, be: 2'b00, data: {alu_res, alu_res}};
		next_flags = flags;
		mem_write = '{addr: inst[23:8], data: {8'h00, x[7:0]}, be: 2'b00};
		branch_taken = 1'b0;
		branch_target = rel_target;
		if (execute)
		begin
			case (opcode)
				OP_LD_XL_IMMD:
				begin
					reg_write.data = {imm8, imm8};
					reg_write.be = 2'b01;
				end
				OP_LD_XL_DIR, OP_LD_XL_IY:
				begin
					reg_write.data = {mem8, mem8};
					reg_write.be = 2'b01;
					next_flags.z = (mem8 == 8'h00);
					next_flags.n = mem8[7];
				end
				OP_LDW_Y_IMMD:
				begin
					reg_write.target_y = 1'b1;
					reg_write.data = inst[23:8];
					reg_write.be = 2'b11;
					next_flags.z = (inst[23:8] == 16'h0000);
					next_flags.n = inst[23];
				end
				OP_LD_DIR_XL:
					mem_write.be = 2'b01;
				OP_ADD_XL_IMMD, OP_SUB_XL_IMMD, OP_ADD_XL_DIR:
				begin
					reg_write.be = 2'b01;
					next_flags.z = (alu_res == 8'h00);
					next_flags.n = alu_res[7];
					next_flags.c = sum9[8];
				end
				OP_AND_XL_IMMD, OP_OR_XL_IMMD, OP_XOR_XL_IMMD:
				begin
					reg_write.be = 2'b01;
					next_flags.z = (alu_res == 8'h00);
					next_flags.n = alu_res[7];
				end
				OP_JR_D: branch_taken = 1'b1;
				OP_JRZ_D: branch_taken = flags.z;
				OP_JRNZ_D: branch_taken = !flags.z;
				OP_JRC_D: branch_taken = flags.c;
				OP_JP_IMMD:
				begin
					branch_taken = 1'b1;
					branch_target = inst[23:8];
				end
				default:
				begin
					// nop, trap and unknown opcodes change nothing
					branch_taken = 1'b0;
				end
			endcase
		end
	end

endmodule

/* verilog/f8_core.sv */
/*
  Reduced f8-style 8-bit core on a split even/odd byte memory.
  Both banks need a one-cycle synchronous read and accept writes every cycle.
  Execution starts at RESET_PC in the first cycle after reset.
  trap stays high while a trap instruction is held.
*/
`timescale 1ns/1ps

module f8_core import f8_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic [DATA_W-1:0] read_data_even,
	input logic [DATA_W-1:0] read_data_odd,
	output bank_port_t bank_even,
	output bank_port_t bank_odd,
	output logic trap
);

	logic [ADDR_W-1:0] x, y, pc, next_pc;
	logic [ADDR_W-1:0] fetch_addr, operand_addr, read_word, branch_target;
	logic [23:0] inst;
	logic execute, branch_taken;
	flags_t flags, next_flags;
	reg_write_t reg_write;
	mem_write_t mem_write;
	fetch_phase_t phase;

	f8_regfile u_regfile (.clk(clk), .reset(reset), .reg_write(reg_write),
		.next_flags(next_flags), .next_pc(next_pc), .x(x), .y(y), .pc(pc), .flags(flags));

	f8_mem_arbiter u_arbiter (.clk(clk), .reset(reset), .phase(phase),
		.fetch_addr(fetch_addr), .operand_addr(operand_addr), .mem_write(mem_write),
		.read_data_even(read_data_even), .read_data_odd(read_data_odd),
		.bank_even(bank_even), .bank_odd(bank_odd), .read_word(read_word));

	f8_fetch u_fetch (.clk(clk), .reset(reset), .read_word(read_word), .pc(pc),
		.branch_taken(branch_taken), .branch_target(branch_target), .trap(trap),
		.inst(inst), .execute(execute), .phase(phase), .fetch_addr(fetch_addr),
		.next_pc(next_pc));

	f8_execute u_execute (.inst(inst), .execute(execute), .read_word(read_word),
		.x(x), .y(y), .pc(pc), .flags(flags), .operand_addr(operand_addr),
		.reg_write(reg_write), .next_flags(next_flags), .mem_write(mem_write),
		.branch_taken(branch_taken), .branch_target(branch_target), .trap(trap));

endmodule

/* verification/f8_mem_model.sv */
/*
  Two-bank byte memory for the core testbench, one-cycle synchronous read.
  Unwritten bytes hold a fill derived from the full byte address.
  Every bank write goes into a log of 1024 entries, later writes only count.
  Logged addresses are byte addresses, so bit 0 tells the bank lane.
*/
`timescale 1ns/1ps

module f8_mem_model import f8_pkg::*;
(
	input logic clk,
	input bank_port_t bank_even,
	input bank_port_t bank_odd,
	output logic [DATA_W-1:0] read_data_even,
	output logic [DATA_W-1:0] read_data_odd
);

	logic [DATA_W-1:0] even_mem [0:(1 << BANK_ADDR_W)-1];
	logic [DATA_W-1:0] odd_mem [0:(1 << BANK_ADDR_W)-1];
	logic [ADDR_W-1:0] log_addr [0:1023];
	logic [DATA_W-1:0] log_data [0:1023];
	int write_count;

	function automatic logic [DATA_W-1:0] fill_byte(input logic [ADDR_W-1:0] addr);
		return addr[15:8] ^ {addr[6:0], addr[7]} ^ 8'h3c;
	endfunction

	task automatic poke(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		if (addr[0])
			odd_mem[addr[15:1]] = data;
		else
			even_mem[addr[15:1]] = data;
	endtask

	task automatic append_log(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		if (write_count < 1024)
		begin
			log_addr[write_count[9:0]] = addr;
			log_data[write_count[9:0]] = data;
		end
		write_count = write_count + 1;
	endtask

	initial
	begin
		write_count = 0;
		read_data_even <= 8'h00;
		read_data_odd <= 8'h00;
		for (int i = 0; i < (1 << BANK_ADDR_W); i++)
		begin
			even_mem[15'(i)] = fill_byte(16'(2 * i));
			odd_mem[15'(i)] = fill_byte(16'(2 * i + 1));
		end
	end

	// read old data before this edge's writes
	always @(posedge clk)
	begin
		read_data_even <= even_mem[bank_even.read_addr];
		read_data_odd <= odd_mem[bank_odd.read_addr];
		if (bank_even.write_en)
		begin
			append_log({bank_even.write_addr, 1'b0}, bank_even.write_data);
			even_mem[bank_even.write_addr] = bank_even.write_data;
		end
		if (bank_odd.write_en)
		begin
			append_log({bank_odd.write_addr, 1'b1}, bank_odd.write_data);
			odd_mem[bank_odd.write_addr] = bank_odd.write_data;
		end
	end

endmodule

/* verification/f8_core_tb.sv */
/*
  Directed tests for the reduced f8 core.
  Each test loads a program at RESET_PC while reset is high, releases reset
  and runs until trap, then compares the memory write log.
  Programs end in trap; a run without trap counts as an error.
  Inputs change on the falling clock edge, outputs are sampled there too.
*/
`timescale 1ns/1ps

module f8_core_tb import f8_pkg::*;
();

	logic clk;
	logic reset;
	logic [DATA_W-1:0] read_data_even;
	logic [DATA_W-1:0] read_data_odd;
	bank_port_t bank_even;
	bank_port_t bank_odd;
	logic trap;

	int seed = 85;
	int errors;
	int checks;
	logic [ADDR_W-1:0] load_ptr;
	logic [ADDR_W-1:0] exp_addr [$];
	logic [DATA_W-1:0] exp_data [$];

	f8_core UUT (.clk(clk), .reset(reset), .read_data_even(read_data_even),
		.read_data_odd(read_data_odd), .bank_even(bank_even), .bank_odd(bank_odd),
		.trap(trap));

	f8_mem_model u_mem (.clk(clk), .bank_even(bank_even), .bank_odd(bank_odd),
		.read_data_even(read_data_even), .read_data_odd(read_data_odd));

	always #4 clk = ~clk;

	task automatic check_value(input string what, input int got, input int exp);
		checks++;
		assert (got == exp)
		else
		begin
			errors++;
			$display("Fail %0t: %s got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic emit(input logic [DATA_W-1:0] b);
		u_mem.poke(load_ptr, b);
		load_ptr = load_ptr + 16'd1;
	endtask

	task automatic emit2(input logic [DATA_W-1:0] op, input logic [DATA_W-1:0] b);
		emit(op);
		emit(b);
	endtask

	task automatic emit3(input logic [DATA_W-1:0] op, input logic [ADDR_W-1:0] w);
		emit(op);
		emit(w[7:0]);
		emit(w[15:8]);
	endtask

	task automatic expect_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	// store of xl that is expected to happen
	task automatic emit_store(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		emit3(OP_LD_DIR_XL, addr);
		expect_write(addr, data);
	endtask

	// core is held in reset while the program is written
	task automatic start_program();
		@(negedge clk);
		reset = 1'b1;
		load_ptr = RESET_PC;
		exp_addr.delete();
		exp_data.delete();
	endtask

	task automatic run_program(input string name);
		int base;
		int cycles;
		int count;
		base = u_mem.write_count;
		for (int i = 0; i < 8; i++)
		begin
			@(negedge clk);
			check_value({name, " write enable in reset"},
				int'({bank_even.write_en, bank_odd.write_en}), 0);
			check_value({name, " trap in reset"}, int'(trap), 0);
		end
		reset = 1'b0;
		cycles = 0;
		while (!trap && cycles < 500)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!trap)
		begin
			errors++;
			$display("%s timed out waiting for trap after %0d cycles", name, cycles);
		end
		else
		begin
			// pc holds on trap, so nothing else may be written
			for (int i = 0; i < 8; i++)
			begin
				@(negedge clk);
				check_value({name, " trap held"}, int'(trap), 1);
			end
			count = u_mem.write_count - base;
			check_value({name, " write count"}, count, exp_addr.size());
			for (int k = 0; k < exp_addr.size() && k < count; k++)
			begin
				check_value({name, " write address"}, int'(u_mem.log_addr[base + k]),
					int'(exp_addr[k]));
				check_value({name, " write data"}, int'(u_mem.log_data[base + k]),
					int'(exp_data[k]));
			end
		end
	endtask

	task automatic test_load_store();
		start_program();
		emit2(OP_LD_XL_IMMD, 8'ha5);
		emit_store(16'h6000, 8'ha5);
		emit_store(16'h6001, 8'ha5);
		emit(OP_TRAP);
		run_program("load store");
	endtask

	task automatic test_alu_immediate();
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		logic [DATA_W-1:0] r;
		opcode_t op;
		for (int i = 0; i < 10; i++)
		begin
			a = 8'($random(seed));
			b = 8'($random(seed));
			case (i % 5)
				0:
				begin
					op = OP_ADD_XL_IMMD;
					r = a + b;
				end
				1:
				begin
					op = OP_SUB_XL_IMMD;
					r = a - b;
				end
				2:
				begin
					op = OP_AND_XL_IMMD;
					r = a & b;
				end
				3:
				begin
					op = OP_OR_XL_IMMD;
					r = a | b;
				end
				default:
				begin
					op = OP_XOR_XL_IMMD;
					r = a ^ b;
				end
			endcase
			start_program();
			emit2(OP_LD_XL_IMMD, a);
			emit2(op, b);
			emit_store(16'h6010 + 16'(i), r);
			emit(OP_TRAP);
			run_program("alu immediate");
		end
	endtask

	// odd and even operand addresses, direct and through y
	task automatic test_memory_operands();
		logic [DATA_W-1:0] p1;
		logic [DATA_W-1:0] p2;
		logic [DATA_W-1:0] p3;
		logic [DATA_W-1:0] p4;
		p1 = 8'($random(seed));
		p2 = 8'($random(seed));
		p3 = 8'($random(seed));
		p4 = 8'($random(seed));
		start_program();
		u_mem.poke(16'h5001, p1);
		u_mem.poke(16'h5002, p2);
		u_mem.poke(16'h5007, p3);
		u_mem.poke(16'h5008, p4);
		emit3(OP_LD_XL_DIR, 16'h5001);
		emit_store(16'h6020, p1);
		emit3(OP_ADD_XL_DIR, 16'h5002);
		emit_store(16'h6021, p1 + p2);
		emit3(OP_LDW_Y_IMMD, 16'h5007);
		emit(OP_LD_XL_IY);
		emit_store(16'h6022, p3);
		emit3(OP_LDW_Y_IMMD, 16'h5008);
		emit(OP_LD_XL_IY);
		emit_store(16'h6023, p4);
		emit(OP_TRAP);
		run_program("memory operands");
	endtask

	task automatic test_branches();
		logic [DATA_W-1:0] v;
		logic [DATA_W-1:0] a;
		v = 8'($random(seed));
		a = 8'($random(seed)) | 8'h80;
		start_program();
		emit2(OP_LD_XL_IMMD, v);
		emit2(OP_SUB_XL_IMMD, v);
		// displacement 5 skips the branch itself and one store
		emit2(OP_JRZ_D, 8'd5);
		emit3(OP_LD_DIR_XL, 16'h6030);
		emit2(OP_JRNZ_D, 8'd5);
		emit_store(16'h6031, 8'h00);
		emit2(OP_LD_XL_IMMD, a);
		emit2(OP_ADD_XL_IMMD, 8'h80);
		emit2(OP_JRC_D, 8'd5);
		emit3(OP_LD_DIR_XL, 16'h6032);
		emit3(OP_JP_IMMD, 16'h5800);
		emit3(OP_LD_DIR_XL, 16'h6033);
		emit(OP_TRAP);
		load_ptr = 16'h5800;
		emit_store(16'h6034, a + 8'h80);
		emit(OP_TRAP);
		run_program("branches");
	endtask

	task automatic test_reset();
		logic [DATA_W-1:0] v;
		v = 8'($random(seed));
		start_program();
		emit2(OP_LD_XL_IMMD, v);
		emit_store(16'h6041, v);
		emit(OP_TRAP);
		run_program("reset first run");
		// rerun the same program from unchanged memory
		start_program();
		expect_write(16'h6041, v);
		run_program("reset second run");
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		errors = 0;
		checks = 0;
		load_ptr = RESET_PC;
		test_load_store();
		test_alu_immediate();
		test_memory_operands();
		test_branches();
		test_reset();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

/* f8_core.f */
verilog/f8_pkg.sv
verilog/f8_regfile.sv
verilog/f8_mem_arbiter.sv
verilog/f8_fetch.sv
verilog/f8_execute.sv
verilog/f8_core.sv
verification/f8_mem_model.sv
verification/f8_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= f8_core_tb
FILELIST ?= f8_core.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "All checks passed" $(LOG) || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
